// ==== all.f ====
+incdir+verilog
verilog/soc_interconnect_pkg.sv
verilog/soc_req_if.sv
verilog/l2_private_bank.sv
verilog/tcdm_addr_decoder.sv
verilog/soc_req_fifo.sv
verilog/soc_target_port.sv
verilog/soc_interconnect_wrap.sv
dv/tb_soc_interconnect.sv

// ==== dv/tb_soc_interconnect.sv ====
/*
 * Testbench for the fabric controller data port.
 * Drives TCDM requests, models an APB slave and predicts every response.
 * Concurrent assertions check responses in grant order and the APB protocol.
 */

`default_nettype none

`include "soc_cfg.svh"

module tb_soc_interconnect;
    import soc_interconnect_pkg::*;

    // Expected response; mask selects the data bits that are checked
    typedef struct packed {
        logic  opc;
        data_t data;
        data_t mask;
    } rsp_t;

    logic  clk_i, arst_n_i, req_i, wen_i, gnt_o;
    logic  r_valid_o, r_opc_o, psel_o, penable_o, pwrite_o, pready_i, pslverr_i;
    addr_t add_i, paddr_o;
    data_t wdata_i, r_rdata_o, pwdata_o, prdata_i;
    be_t   be_i;

    rsp_t  exp_q [$];
    rsp_t  exp_head;
    logic  exp_avail;
    int    err_cnt, pass_cnt, fail_cnt, issued, cycles, stall_cnt;
    logic  idle_chk, no_apb, slow_slave;

    // Reference model state
    data_t ref_bank [int];
    data_t ref_bank_mask [int];
    data_t ref_periph [addr_t];

    // APB slave model state
    data_t slave_mem [addr_t];
    int    wait_left;
    logic  rdy_next, err_next;
    data_t rdata_next;

    soc_interconnect_wrap dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Run limit grows with the number of requests issued
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 20 * issued + 200) begin
            $display("timeout: run stuck after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // APB slave model, looks at the bus on negedge, drives on posedge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        rdy_next = 1'b0;
        if (psel_o && !penable_o) begin
            // Address phase, pick 0 to 3 wait states
            wait_left  = slow_slave ? 3 : $urandom_range(3);
            rdy_next   = (wait_left == 0);
            err_next   = (paddr_o[15:12] == 4'hF);
            rdata_next = slave_mem.exists(paddr_o) ? slave_mem[paddr_o] : ~paddr_o;
        end else if (penable_o && !pready_i) begin
            wait_left--;
            rdy_next = (wait_left == 0);
        end else if (penable_o && pready_i && pwrite_o && !pslverr_i) begin
            slave_mem[paddr_o] = pwdata_o;
        end
    end

    always @(posedge clk_i) begin
        pready_i  <= rdy_next;
        pslverr_i <= err_next;
        prdata_i  <= rdata_next;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and response checking
    //////////////////////////////////////////////////////////////////////

    task automatic model_request(input addr_t addr, input logic wen, input data_t wdata,
                                 input be_t be);
        addr_t a;
        rsp_t  rsp;
        data_t d;
        data_t m;
        int    w;
        a   = addr;
        rsp = '{opc: 1'b1, data: '0, mask: '1};
        // Legacy alias folds onto the remap prefix
        if (a[31:20] == `SOC_ALIAS_PREFIX) begin
            a[31:20] = `SOC_REMAP_PREFIX;
        end
        if (a >= `SOC_MEM_MAP_PRIVATE_BANK_START_ADDR &&
            a <= `SOC_MEM_MAP_PRIVATE_BANK_END_ADDR) begin
            w = int'((a - `SOC_MEM_MAP_PRIVATE_BANK_START_ADDR) >> 2);
            d = ref_bank.exists(w) ? ref_bank[w] : '0;
            m = ref_bank_mask.exists(w) ? ref_bank_mask[w] : '0;
            rsp.opc  = 1'b0;
            rsp.mask = '0;
            if (!wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        d[8*b +: 8] = wdata[8*b +: 8];
                        m[8*b +: 8] = 8'hFF;
                    end
                end
                ref_bank[w]      = d;
                ref_bank_mask[w] = m;
            end else begin
                // Only bytes written so far are known
                rsp.data = d;
                rsp.mask = m;
            end
        end else if (a >= `SOC_MEM_MAP_PERIPHERALS_START_ADDR &&
                     a <= `SOC_MEM_MAP_PERIPHERALS_END_ADDR) begin
            rsp.opc  = (a[15:12] == 4'hF);
            rsp.mask = '0;
            if (!wen && !rsp.opc) begin
                ref_periph[a] = wdata;
            end else if (wen && !rsp.opc) begin
                rsp.data = ref_periph.exists(a) ? ref_periph[a] : ~a;
                rsp.mask = '1;
            end
        end
        exp_q.push_back(rsp);
    endtask

    // Head of the queue for the response seen at the next posedge
    always @(negedge clk_i) begin
        exp_avail = 1'b0;
        if (r_valid_o && exp_q.size() != 0) begin
            exp_head  = exp_q.pop_front();
            exp_avail = 1'b1;
        end
    end

    always @(negedge clk_i) begin
        if (req_i && !gnt_o) begin
            stall_cnt++;
        end
    end

    a_rsp_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r_valid_o |-> exp_avail)
        else begin
            $display("response arrived with no granted request pending");
            err_cnt++;
        end

    a_rsp_opc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r_valid_o && exp_avail |-> r_opc_o == exp_head.opc)
        else begin
            $display("Mismatch r_opc_o: got %h expected %h", $sampled(r_opc_o), exp_head.opc);
            err_cnt++;
        end

    a_rsp_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r_valid_o && exp_avail |-> ((r_rdata_o ^ exp_head.data) & exp_head.mask) == '0)
        else begin
            $display("Mismatch r_rdata_o: got %h expected %h mask %h",
                     $sampled(r_rdata_o), exp_head.data, exp_head.mask);
            err_cnt++;
        end

    // SETUP is one cycle, then ACCESS with the same address and controls
    a_apb_setup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psel_o && !penable_o |=> psel_o && penable_o && $stable(paddr_o)
            && $stable(pwrite_o) && $stable(pwdata_o))
        else begin
            $display("APB setup phase not followed by a matching access phase");
            err_cnt++;
        end

    a_apb_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        penable_o && !pready_i |=> psel_o && penable_o && $stable(paddr_o)
            && $stable(pwrite_o) && $stable(pwdata_o))
        else begin
            $display("APB access phase changed or ended before pready");
            err_cnt++;
        end

    a_apb_end: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        penable_o && pready_i |=> !penable_o)
        else begin
            $display("APB access phase went on after pready");
            err_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        idle_chk |-> !r_valid_o && !psel_o && !penable_o)
        else begin
            $display("outputs not idle after reset");
            err_cnt++;
        end

    a_apb_unused: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        no_apb |-> !psel_o)
        else begin
            $display("APB selected by an unmapped access");
            err_cnt++;
        end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Called on a posedge, returns on the posedge that took the grant
    task automatic send(input addr_t addr, input logic wen, input data_t wdata, input be_t be);
        logic granted;
        req_i   <= 1'b1;
        add_i   <= addr;
        wen_i   <= wen;
        wdata_i <= wdata;
        be_i    <= be;
        do begin
            @(negedge clk_i);
            granted = gnt_o;
            @(posedge clk_i);
        end while (!granted);
        model_request(addr, wen, wdata, be);
        issued++;
    endtask

    task automatic drain();
        req_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int        e0;
        bank_idx_t picks [6];
        void'($urandom(32'haf2b));
        arst_n_i   = 1'b0;
        req_i      = 1'b0;
        add_i      = '0;
        wen_i      = 1'b1;
        wdata_i    = '0;
        be_i       = '0;
        prdata_i   = '0;
        pready_i   = 1'b0;
        pslverr_i  = 1'b0;
        rdy_next   = 1'b0;
        err_next   = 1'b0;
        rdata_next = '0;
        exp_avail  = 1'b0;
        idle_chk   = 1'b0;
        no_apb     = 1'b0;
        slow_slave = 1'b0;
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        idle_chk <= 1'b1;

        // Quiet outputs before any request
        e0 = err_cnt;
        repeat (4) @(posedge clk_i);
        idle_chk <= 1'b0;
        end_test("reset_idle", e0);

        // Byte merges, one partial word and one word never written
        e0 = err_cnt;
        send(32'h1C00_0010, 1'b0, 32'h1122_3344, 4'hF);
        send(32'h1C00_0010, 1'b0, 32'hAABB_CCDD, 4'h5);
        send(32'h1C00_0010, 1'b1, '0, 4'hF);
        send(32'h1C00_0020, 1'b0, 32'h5566_7788, 4'h2);
        send(32'h1C00_0020, 1'b1, '0, 4'hF);
        send(32'h1C00_0300, 1'b1, '0, 4'hF);
        for (int i = 0; i < 6; i++) begin
            picks[i] = bank_idx_t'($urandom_range(255));
            send(32'h1C00_0000 + 32'(picks[i]) * 4, 1'b0, $urandom, be_t'($urandom));
        end
        for (int i = 0; i < 6; i++) begin
            send(32'h1C00_0000 + 32'(picks[i]) * 4, 1'b1, '0, 4'hF);
        end
        drain();
        end_test("bank_bytes", e0);

        // Alias and full address reach the same word
        e0 = err_cnt;
        send(32'h0000_0080, 1'b0, 32'hCAFE_0001, 4'hF);
        send(32'h1C00_0080, 1'b1, '0, 4'hF);
        send(32'h1C00_0084, 1'b0, 32'h0BAD_F00D, 4'hF);
        send(32'h0000_0084, 1'b1, '0, 4'hF);
        drain();
        end_test("alias_remap", e0);

        e0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            send(32'h1A10_0100 + 32'(4 * i), 1'b0, $urandom, 4'hF);
        end
        for (int i = 0; i < 4; i++) begin
            send(32'h1A10_0100 + 32'(4 * i), 1'b1, '0, 4'hF);
        end
        send(32'h1A10_0200, 1'b1, '0, 4'hF);
        // Slave error window at bits 15:12 = F
        send(32'h1A10_F004, 1'b0, 32'h1234_5678, 4'hF);
        send(32'h1A10_F004, 1'b1, '0, 4'hF);
        drain();
        end_test("periph_apb", e0);

        e0 = err_cnt;
        no_apb <= 1'b1;
        send(32'h3000_0000, 1'b1, '0, 4'hF);
        send(32'h3000_0000, 1'b0, 32'hDEAD_BEEF, 4'hF);
        send(32'h1C00_0400, 1'b1, '0, 4'hF);
        send(32'h1A11_0000, 1'b1, '0, 4'hF);
        send(32'h0010_0000, 1'b1, '0, 4'hF);
        drain();
        no_apb <= 1'b0;
        end_test("unmapped", e0);

        // Slowest slave with a full FIFO behind it
        e0 = err_cnt;
        slow_slave <= 1'b1;
        stall_cnt = 0;
        for (int i = 0; i < 12; i++) begin
            case (i % 3)
                0: send(32'h1A10_0400, 1'(i % 2), $urandom, 4'hF);
                1: send(32'h1C00_0200 + 32'(4 * i), 1'b0, $urandom, 4'hF);
                default: send(32'h3000_0000 + 32'(i), 1'b1, '0, 4'hF);
            endcase
        end
        drain();
        slow_slave <= 1'b0;
        if (stall_cnt == 0) begin
            $display("grant never dropped under back-pressure");
            err_cnt++;
        end
        end_test("backpressure_order", e0);

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/soc_interconnect_wrap.sv ====
/*
 * Fabric controller data port into the SoC memory map.
 * TCDM slave in, APB master out; the private bank sits inside.
 * Decoder feeds a request FIFO that feeds the target port.
 */

`default_nettype none

module soc_interconnect_wrap (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    // TCDM slave side
    input  wire logic                        req_i,
    input  wire soc_interconnect_pkg::addr_t add_i,
    input  wire logic                        wen_i,
    input  wire soc_interconnect_pkg::data_t wdata_i,
    input  wire soc_interconnect_pkg::be_t   be_i,
    output logic                             gnt_o,
    output logic                             r_valid_o,
    output soc_interconnect_pkg::data_t      r_rdata_o,
    output logic                             r_opc_o,
    // APB master side
    output soc_interconnect_pkg::addr_t      paddr_o,
    output logic                             psel_o,
    output logic                             penable_o,
    output logic                             pwrite_o,
    output soc_interconnect_pkg::data_t      pwdata_o,
    input  wire soc_interconnect_pkg::data_t prdata_i,
    input  wire logic                        pready_i,
    input  wire logic                        pslverr_i
);

    soc_req_if dec_to_fifo ();
    soc_req_if fifo_to_tgt ();

    tcdm_addr_decoder i_decoder (
        .clk_i, .arst_n_i, .req_i, .add_i, .wen_i, .wdata_i, .be_i, .gnt_o,
        .req_o (dec_to_fifo.producer)
    );

    soc_req_fifo i_req_fifo (
        .clk_i, .arst_n_i,
        .push_i (dec_to_fifo.consumer),
        .pop_o  (fifo_to_tgt.producer)
    );

    soc_target_port i_target_port (
        .clk_i, .arst_n_i,
        .req_i (fifo_to_tgt.consumer),
        .r_valid_o, .r_rdata_o, .r_opc_o,
        .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o,
        .prdata_i, .pready_i, .pslverr_i
    );

endmodule

`default_nettype wire

// ==== verilog/soc_target_port.sv ====
/*
 * Executes queued requests on the private bank or on APB.
 * Bank and unmapped requests answer one cycle after the pop;
 * peripheral requests run SETUP then ACCESS and answer the cycle
 * after pready. Nothing is popped while APB is busy.
 */

`default_nettype none

module soc_target_port (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    soc_req_if.consumer                      req_i,
    output logic                             r_valid_o,
    output soc_interconnect_pkg::data_t      r_rdata_o,
    output logic                             r_opc_o,
    output soc_interconnect_pkg::addr_t      paddr_o,
    output logic                             psel_o,
    output logic                             penable_o,
    output logic                             pwrite_o,
    output soc_interconnect_pkg::data_t      pwdata_o,
    input  wire soc_interconnect_pkg::data_t prdata_i,
    input  wire logic                        pready_i,
    input  wire logic                        pslverr_i
);
    import soc_interconnect_pkg::*;

    apb_state_e state_q;
    logic       pop;
    logic       apb_done;
    logic       bank_en;
    data_t      bank_rdata;

    // Response of the item popped last
    logic       rsp_valid_q;
    logic       rsp_err_q;
    logic       rsp_bank_rd_q;
    data_t      rsp_data_q;

    // APB address and data phase payload
    addr_t      apb_addr_q;
    logic       apb_write_q;
    data_t      apb_wdata_q;

    assign req_i.ready = (state_q == APB_IDLE);
    assign pop         = req_i.valid && req_i.ready;
    assign apb_done    = (state_q == APB_ACCESS) && pready_i;
    assign bank_en     = pop && (req_i.target == TGT_PRIV_BANK);

    // Word index from the byte address
    l2_private_bank i_priv_bank (
        .clk_i   (clk_i),
        .en_i    (bank_en),
        .we_i    (!req_i.wen),
        .idx_i   (req_i.addr[9:2]),
        .wdata_i (req_i.wdata),
        .be_i    (req_i.be),
        .rdata_o (bank_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Dispatch and APB phase machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= APB_IDLE;
            rsp_valid_q   <= 1'b0;
            rsp_err_q     <= 1'b0;
            rsp_bank_rd_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                APB_IDLE: begin
                    if (pop && req_i.target == TGT_PERIPH) begin
                        state_q <= APB_SETUP;
                    end else if (pop) begin
                        // Bank or unmapped, answer on the next cycle
                        rsp_valid_q   <= 1'b1;
                        rsp_err_q     <= (req_i.target == TGT_UNMAPPED);
                        rsp_bank_rd_q <= (req_i.target == TGT_PRIV_BANK) && req_i.wen;
                    end
                end
                APB_SETUP: begin
                    state_q <= APB_ACCESS;
                end
                APB_ACCESS: begin
                    // Wait states until the slave is ready
                    if (pready_i) begin
                        state_q       <= APB_IDLE;
                        rsp_valid_q   <= 1'b1;
                        rsp_err_q     <= pslverr_i;
                        rsp_bank_rd_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= APB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            // Write and unmapped responses carry zero data
            rsp_data_q  <= '0;
            apb_addr_q  <= req_i.addr;
            apb_write_q <= !req_i.wen;
            apb_wdata_q <= req_i.wdata;
        end
        if (apb_done) begin
            rsp_data_q <= apb_write_q ? '0 : prdata_i;
        end
    end

    assign psel_o    = (state_q != APB_IDLE);
    assign penable_o = (state_q == APB_ACCESS);
    assign paddr_o   = apb_addr_q;
    assign pwrite_o  = apb_write_q;
    assign pwdata_o  = apb_wdata_q;

    // Bank read data arrives straight from the memory
    assign r_valid_o = rsp_valid_q;
    assign r_rdata_o = rsp_bank_rd_q ? bank_rdata : rsp_data_q;
    assign r_opc_o   = rsp_err_q;

    a_paddr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        penable_o |-> $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o));

endmodule

`default_nettype wire

// ==== verilog/soc_req_fifo.sv ====
/*
 * In-order request buffer between decoder and target port.
 * Circular buffer with read/write pointers and an entry count.
 * A pushed entry shows at the output one cycle later.
 */

`default_nettype none

`include "soc_cfg.svh"

module soc_req_fifo (
    input  wire logic   clk_i,
    input  wire logic   arst_n_i,
    soc_req_if.consumer push_i,
    soc_req_if.producer pop_o
);
    import soc_interconnect_pkg::*;

    localparam int DEPTH = `SOC_REQ_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage, one array per field
    addr_t   addr_mem   [DEPTH];
    logic    wen_mem    [DEPTH];
    data_t   wdata_mem  [DEPTH];
    be_t     be_mem     [DEPTH];
    target_e target_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_i.ready = (count_q != CNT_W'(DEPTH));
    assign pop_o.valid  = (count_q != '0);
    assign do_push      = push_i.valid && push_i.ready;
    assign do_pop       = pop_o.valid && pop_o.ready;

    // Head entry
    assign pop_o.addr   = addr_mem[rd_ptr_q];
    assign pop_o.wen    = wen_mem[rd_ptr_q];
    assign pop_o.wdata  = wdata_mem[rd_ptr_q];
    assign pop_o.be     = be_mem[rd_ptr_q];
    assign pop_o.target = target_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            addr_mem[wr_ptr_q]   <= push_i.addr;
            wen_mem[wr_ptr_q]    <= push_i.wen;
            wdata_mem[wr_ptr_q]  <= push_i.wdata;
            be_mem[wr_ptr_q]     <= push_i.be;
            target_mem[wr_ptr_q] <= push_i.target;
        end
    end

    // Head holds until the target port takes it
    a_head_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (pop_o.valid && !pop_o.ready) |=> pop_o.valid && $stable(pop_o.addr)
            && $stable(pop_o.wen) && $stable(pop_o.wdata) && $stable(pop_o.be)
            && $stable(pop_o.target));

endmodule

`default_nettype wire

// ==== verilog/tcdm_addr_decoder.sv ====
/*
 * TCDM front end of the fabric controller data port.
 * Grants a request when the FIFO can take it, folds the legacy
 * 0x000 prefix onto 0x1C0 and tags the request with its target.
 * No added latency: the request enters the FIFO on the grant edge.
 */

`default_nettype none

`include "soc_cfg.svh"

module tcdm_addr_decoder (
    input  wire logic                        clk_i,
    input  wire logic                        arst_n_i,
    input  wire logic                        req_i,
    input  wire soc_interconnect_pkg::addr_t add_i,
    input  wire logic                        wen_i,
    input  wire soc_interconnect_pkg::data_t wdata_i,
    input  wire soc_interconnect_pkg::be_t   be_i,
    output logic                             gnt_o,
    soc_req_if.producer                      req_o
);
    import soc_interconnect_pkg::*;

    addr_t   remap_addr;
    target_e target;

    //////////////////////////////////////////////////////////////////////
    // Alias remap and region decode
    //////////////////////////////////////////////////////////////////////

    // Legacy alias, e.g. 0x0000_1234 lands on 0x1C00_1234
    always_comb begin
        remap_addr = add_i;
        if (add_i[31:20] == `SOC_ALIAS_PREFIX) begin
            remap_addr[31:20] = `SOC_REMAP_PREFIX;
        end
    end

    // Rule table, anything outside both regions is unmapped
    always_comb begin
        target = TGT_UNMAPPED;
        if (remap_addr >= `SOC_MEM_MAP_PRIVATE_BANK_START_ADDR &&
            remap_addr <= `SOC_MEM_MAP_PRIVATE_BANK_END_ADDR) begin
            target = TGT_PRIV_BANK;
        end else if (remap_addr >= `SOC_MEM_MAP_PERIPHERALS_START_ADDR &&
                     remap_addr <= `SOC_MEM_MAP_PERIPHERALS_END_ADDR) begin
            target = TGT_PERIPH;
        end
    end

    // Master holds req and payload until granted
    assign req_o.valid  = req_i;
    assign req_o.addr   = remap_addr;
    assign req_o.wen    = wen_i;
    assign req_o.wdata  = wdata_i;
    assign req_o.be     = be_i;
    assign req_o.target = target;

    // Back-pressure from a full FIFO removes the grant
    assign gnt_o = req_i && req_o.ready;

    // A stalled TCDM request keeps its payload until the grant
    a_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (req_i && !gnt_o) |=> req_i && $stable(add_i) && $stable(wen_i)
            && $stable(wdata_i) && $stable(be_i));

endmodule

`default_nettype wire

// ==== verilog/l2_private_bank.sv ====
/*
 * Private L2 word memory, single port.
 * Synchronous read, byte-enabled write; contents survive reset.
 */

`default_nettype none

`include "soc_cfg.svh"

module l2_private_bank (
    input  wire logic                            clk_i,
    input  wire logic                            en_i,
    input  wire logic                            we_i,
    input  wire soc_interconnect_pkg::bank_idx_t idx_i,
    input  wire soc_interconnect_pkg::data_t     wdata_i,
    input  wire soc_interconnect_pkg::be_t       be_i,
    output soc_interconnect_pkg::data_t          rdata_o
);
    import soc_interconnect_pkg::*;

    data_t mem [`SOC_BANK_WORDS];
    data_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            // Only enabled bytes change
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end else if (en_i) begin
            rdata_q <= mem[idx_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/soc_req_if.sv ====
/*
 * Valid/ready request channel inside the data port.
 * Producer raises valid with the payload and holds both until ready;
 * a transfer happens on a cycle with valid and ready high.
 */

`default_nettype none

interface soc_req_if;
    import soc_interconnect_pkg::*;

    logic    valid;
    logic    ready;
    addr_t   addr;
    // High for read, low for write, as on TCDM
    logic    wen;
    data_t   wdata;
    be_t     be;
    target_e target;

    modport producer (output valid, addr, wen, wdata, be, target, input ready);

    modport consumer (input valid, addr, wen, wdata, be, target, output ready);

endinterface

`default_nettype wire

// ==== verilog/soc_interconnect_pkg.sv ====
/*
 * Shared types of the SoC data port: bus widths with a meaning,
 * the decoded target and the APB bridge phases.
 * Compile before every other design file.
 */

`default_nettype none

package soc_interconnect_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;
    // Word index into the private bank
    typedef logic [7:0]  bank_idx_t;

    // Destination chosen by the address decoder
    typedef enum logic [1:0] {
        TGT_PRIV_BANK,
        TGT_PERIPH,
        TGT_UNMAPPED
    } target_e;

    // APB master phase
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

endpackage

`default_nettype wire

// ==== verilog/soc_cfg.svh ====
/*
 * Memory map and sizing for the fabric controller data port.
 * Included by the decoder, the request FIFO and the private bank.
 * Region bounds are inclusive byte addresses.
 */

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Private L2 region, both contiguous banks as one 256 word block
`define SOC_MEM_MAP_PRIVATE_BANK_START_ADDR 32'h1C00_0000
`define SOC_MEM_MAP_PRIVATE_BANK_END_ADDR   32'h1C00_03FF

// Peripheral region behind the APB master
`define SOC_MEM_MAP_PERIPHERALS_START_ADDR  32'h1A10_0000
`define SOC_MEM_MAP_PERIPHERALS_END_ADDR    32'h1A10_FFFF

// Legacy alias, upper twelve address bits
`define SOC_ALIAS_PREFIX   12'h000
`define SOC_REMAP_PREFIX   12'h1C0

`define SOC_REQ_FIFO_DEPTH 4
`define SOC_BANK_WORDS     256

`endif
